// ==== src/rvv_lsu_pkg.sv ====
`default_nettype none

package rvv_lsu_pkg;

  // decode bandwidth and uop numbering
  parameter int NUM_DE_UOP      = 2;
  parameter int UOP_INDEX_WIDTH = 3;   // up to eight uops per instruction

  parameter int PC_WIDTH        = 32;
  parameter int XLEN            = 32;
  parameter int INST_BITS       = 27;  // encoding bits 31:5
  parameter int VSTART_WIDTH    = 7;
  parameter int VREG_WIDTH      = 5;

  // value doubles as log2(eew/8)
  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } EEW_e;

  typedef struct packed {
    logic       vill;
    logic [2:0] vsew;   // 000 sew8, 001 sew16, 010 sew32
    logic [2:0] vlmul;  // 101..111 fractional, 000..011 integer
  } VTYPE_t;

  typedef struct packed {
    VTYPE_t                  vtype;
    logic [VSTART_WIDTH-1:0] vstart;
  } VECTOR_CSR_t;

  typedef struct packed {
    logic [PC_WIDTH-1:0]  inst_pc;
    logic [INST_BITS-1:0] inst;      // bit 0 is encoding bit 5
    logic [XLEN-1:0]      rs1_data;
    VECTOR_CSR_t          vector_csr;
  } INST_t;

  typedef struct packed {
    logic [PC_WIDTH-1:0]        uop_pc;
    logic [UOP_INDEX_WIDTH-1:0] uop_index;
    logic                       last_uop;
    logic                       is_store;
    EEW_e                       eew;
    logic [VREG_WIDTH-1:0]      vreg;
    logic                       mask_en;
    logic [XLEN-1:0]            rs1_data;
    logic [VSTART_WIDTH-1:0]    vstart_skip;  // element offset, first uop only
  } UOP_t;

endpackage

`default_nettype wire

// ==== src/rvv_uop_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rvv_uop_if #(
  parameter type payload_t   = rvv_lsu_pkg::UOP_t,
  parameter int  QUEUE_DEPTH = 8
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

  // write side, slot 1 only with slot 0
  logic [rvv_lsu_pkg::NUM_DE_UOP-1:0]           wr_valid;
  payload_t [rvv_lsu_pkg::NUM_DE_UOP-1:0]       wr_uop;
  logic [CNT_W-1:0]                             free_count;

  // read side
  logic                                         rd_valid;
  payload_t                                     rd_uop;
  logic                                         rd_pop;

  modport producer (output wr_valid, output wr_uop, input free_count);
  modport queue    (input wr_valid, input wr_uop, output free_count,
                    output rd_valid, output rd_uop, input rd_pop);
  modport consumer (input rd_valid, input rd_uop, output rd_pop);

endinterface

`default_nettype wire

// ==== src/rvv_backend_decode_unit_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_backend_decode_unit_lsu #(
  parameter int VLEN = 128
) (
  input  logic                                           inst_valid,
  input  rvv_lsu_pkg::INST_t                             inst,
  input  logic [rvv_lsu_pkg::UOP_INDEX_WIDTH-1:0]        uop_index_remain,
  output logic [rvv_lsu_pkg::NUM_DE_UOP-1:0]             uop_valid,
  output rvv_lsu_pkg::UOP_t [rvv_lsu_pkg::NUM_DE_UOP-1:0] uop,
  output logic                                           inst_illegal
);

  localparam int         VLENB     = VLEN / 8;
  localparam logic [2:0] VLENB_LOG = 3'($clog2(VLENB));

  logic [5:0]             inst_funct6;   // nf, mew, mop
  logic                   inst_vm;
  logic [4:0]             inst_umop;
  logic [2:0]             inst_funct3;
  logic [4:0]             inst_vd;
  logic [1:0]             inst_opcode;   // encoding bits 6:5
  logic                   vill;
  logic [2:0]             vsew;
  logic [2:0]             vlmul;
  logic [6:0]             vstart;

  rvv_lsu_pkg::EEW_e      eew;
  logic                   eew_ok;
  logic                   lmul_ok;
  logic signed [4:0]      lmul_log;
  logic signed [4:0]      emul_log;
  logic [3:0]             emul_max;      // uops in the register group
  logic [2:0]             elem_shift;    // log2 of elements per register
  logic [6:0]             uop_vstart;
  logic [6:0]             vstart_offset;
  logic                   legal;
  logic [rvv_lsu_pkg::NUM_DE_UOP-1:0][7:0] uop_index_current;

  assign inst_funct6 = inst.inst[26:21];
  assign inst_vm     = inst.inst[20];
  assign inst_umop   = inst.inst[19:15];
  assign inst_funct3 = inst.inst[9:7];
  assign inst_vd     = inst.inst[6:2];
  assign inst_opcode = inst.inst[1:0];
  assign vill        = inst.vector_csr.vtype.vill;
  assign vsew        = inst.vector_csr.vtype.vsew;
  assign vlmul       = inst.vector_csr.vtype.vlmul;
  assign vstart      = inst.vector_csr.vstart;

  always_comb begin
    eew    = rvv_lsu_pkg::EEW8;
    eew_ok = 1'b1;
    case (inst_funct3)
      3'b000:  eew = rvv_lsu_pkg::EEW8;
      3'b101:  eew = rvv_lsu_pkg::EEW16;
      3'b110:  eew = rvv_lsu_pkg::EEW32;
      default: eew_ok = 1'b0;   // eew64 and non-load/store widths
    endcase
  end

  always_comb begin
    lmul_ok  = 1'b1;
    lmul_log = 5'sd0;
    case (vlmul)
      3'b000:  lmul_log = 5'sd0;
      3'b001:  lmul_log = 5'sd1;
      3'b010:  lmul_log = 5'sd2;
      3'b011:  lmul_log = 5'sd3;
      3'b101:  lmul_log = -5'sd3;
      3'b110:  lmul_log = -5'sd2;
      3'b111:  lmul_log = -5'sd1;
      default: lmul_ok  = 1'b0;   // 100 reserved
    endcase
  end

  // emul = eew/sew * lmul, all in log2
  assign emul_log = $signed({3'b000, eew}) - $signed({2'b00, vsew}) + lmul_log;
  assign emul_max = (emul_log <= 5'sd0) ? 4'd1 : (4'd1 << emul_log[1:0]);

  // whole uops before vstart are skipped
  assign elem_shift    = VLENB_LOG - {1'b0, eew};
  assign uop_vstart    = vstart >> elem_shift;
  assign vstart_offset = vstart - (uop_vstart << elem_shift);

  assign legal = (inst_opcode[1] == 1'b0) && (inst_funct6 == 6'd0) &&
                 (inst_umop == 5'd0) && eew_ok && lmul_ok && !vill && !vsew[2] &&
                 (emul_log >= -5'sd3) && (emul_log <= 5'sd3) &&
                 (uop_vstart < {3'b000, emul_max});

  assign inst_illegal = inst_valid & ~legal;

  always_comb begin
    for (int i = 0; i < rvv_lsu_pkg::NUM_DE_UOP; i++) begin
      uop_index_current[i] = {1'b0, uop_vstart} + {5'd0, uop_index_remain} + 8'(i);
      uop_valid[i]         = inst_valid & legal & (uop_index_current[i] < {4'd0, emul_max});
      uop[i].uop_pc        = inst.inst_pc;
      uop[i].uop_index     = uop_index_current[i][2:0];
      uop[i].last_uop      = uop_index_current[i] == ({4'd0, emul_max} - 8'd1);
      uop[i].is_store      = inst_opcode[0];
      uop[i].eew           = eew;
      uop[i].vreg          = inst_vd + {2'b00, uop_index_current[i][2:0]};
      uop[i].mask_en       = ~inst_vm;   // vm=0 is masked
      uop[i].rs1_data      = inst.rs1_data;
      uop[i].vstart_skip   = (uop_index_current[i] == {1'b0, uop_vstart}) ? vstart_offset : 7'd0;
    end
  end

endmodule

`default_nettype wire

// ==== src/rvv_lsu_decode_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_lsu_decode_ctrl #(
  parameter int VLEN = 128
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 inst_valid,
  input  rvv_lsu_pkg::INST_t                   inst,
  output logic                                 inst_ready,
  output logic                                 trap_valid,
  output logic [rvv_lsu_pkg::PC_WIDTH-1:0]     trap_pc,
  rvv_uop_if.producer                          uop_wr
);

  logic                                            busy;      // instruction held
  rvv_lsu_pkg::INST_t                              inst_q;
  logic [rvv_lsu_pkg::UOP_INDEX_WIDTH-1:0]         uop_index_remain;
  logic [rvv_lsu_pkg::NUM_DE_UOP-1:0]              dec_valid;
  rvv_lsu_pkg::UOP_t [rvv_lsu_pkg::NUM_DE_UOP-1:0] dec_uop;
  logic                                            dec_illegal;
  logic                                            wr_fit;
  logic [1:0]                                      wr_num;
  logic                                            wr_last;

  assign inst_ready = ~busy;

  rvv_backend_decode_unit_lsu #(.VLEN(VLEN)) i_decode (
    .inst_valid       (busy),
    .inst             (inst_q),
    .uop_index_remain (uop_index_remain),
    .uop_valid        (dec_valid),
    .uop              (dec_uop),
    .inst_illegal     (dec_illegal)
  );

  // all or nothing per cycle, waits on queue space
  assign wr_num          = dec_valid[1] ? 2'd2 : {1'b0, dec_valid[0]};
  assign wr_fit          = dec_valid[1] ? (uop_wr.free_count >= 2) : (|uop_wr.free_count);
  assign uop_wr.wr_valid = wr_fit ? dec_valid : 2'b00;
  assign uop_wr.wr_uop   = dec_uop;
  assign wr_last         = |(uop_wr.wr_valid & {dec_uop[1].last_uop, dec_uop[0].last_uop});

  always_ff @(posedge clk) begin
    if (reset) begin
      busy             <= 1'b0;
      trap_valid       <= 1'b0;
      uop_index_remain <= '0;
    end else begin
      trap_valid <= dec_illegal;   // single pulse, busy drops with it
      if (inst_valid && !busy) begin
        busy <= 1'b1;
      end else if (dec_illegal || wr_last) begin
        busy <= 1'b0;
      end
      if (dec_illegal || wr_last) begin
        uop_index_remain <= '0;
      end else if (|uop_wr.wr_valid) begin
        uop_index_remain <= uop_index_remain + {1'b0, wr_num};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid && !busy) inst_q <= inst;
    if (dec_illegal) trap_pc <= inst_q.inst_pc;
  end

endmodule

`default_nettype wire

// ==== src/rvv_uop_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_uop_queue #(
  parameter type payload_t   = rvv_lsu_pkg::UOP_t,
  parameter int  QUEUE_DEPTH = 8
) (
  input  logic   clk,
  input  logic   reset,
  rvv_uop_if.queue q
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  payload_t          mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [1:0]        wr_num;
  logic              pop;

  assign wr_num = {1'b0, q.wr_valid[0]} + {1'b0, q.wr_valid[1]};
  assign pop    = q.rd_pop & q.rd_valid;

  assign q.free_count = CNT_W'(QUEUE_DEPTH) - count;   // ignores same-cycle pop
  assign q.rd_valid   = count != '0;
  assign q.rd_uop     = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + PTR_W'(wr_num);
      if (pop) rd_ptr <= rd_ptr + PTR_W'(1);
      count  <= count + CNT_W'(wr_num) - CNT_W'(pop);
    end
  end

  // slot 0 lands first, slot 1 right behind it
  always_ff @(posedge clk) begin
    if (q.wr_valid[0]) mem[wr_ptr] <= q.wr_uop[0];
    if (q.wr_valid[1]) mem[wr_ptr + PTR_W'(1)] <= q.wr_uop[1];
  end

endmodule

`default_nettype wire

// ==== src/rvv_lsu_uop_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_lsu_uop_issue #(
  parameter int VLEN = 128
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   lsu_ready,
  rvv_uop_if.consumer                            uop_rd,
  output logic                                   lsu_valid,
  output logic                                   lsu_store,
  output logic [rvv_lsu_pkg::VREG_WIDTH-1:0]     lsu_vreg,
  output rvv_lsu_pkg::EEW_e                      lsu_eew,
  output logic                                   lsu_mask_en,
  output logic [rvv_lsu_pkg::XLEN-1:0]           lsu_addr,
  output logic [rvv_lsu_pkg::VSTART_WIDTH-1:0]   lsu_vstart_skip,
  output logic                                   lsu_last,
  output logic [rvv_lsu_pkg::PC_WIDTH-1:0]       lsu_pc
);

  localparam int VLENB_LOG = $clog2(VLEN / 8);

  logic                          load_en;   // output register free or draining
  logic [rvv_lsu_pkg::XLEN-1:0]  addr_next;

  assign load_en       = ~lsu_valid | lsu_ready;
  assign uop_rd.rd_pop = uop_rd.rd_valid & load_en;

  // vstart_skip is zero except on the first uop
  assign addr_next = uop_rd.rd_uop.rs1_data
                   + (rvv_lsu_pkg::XLEN'(uop_rd.rd_uop.uop_index) << VLENB_LOG)
                   + (rvv_lsu_pkg::XLEN'(uop_rd.rd_uop.vstart_skip) << uop_rd.rd_uop.eew);

  always_ff @(posedge clk) begin
    if (reset) lsu_valid <= 1'b0;
    else if (load_en) lsu_valid <= uop_rd.rd_valid;
  end

  always_ff @(posedge clk) begin
    if (uop_rd.rd_pop) begin
      lsu_store       <= uop_rd.rd_uop.is_store;
      lsu_vreg        <= uop_rd.rd_uop.vreg;
      lsu_eew         <= uop_rd.rd_uop.eew;
      lsu_mask_en     <= uop_rd.rd_uop.mask_en;
      lsu_addr        <= addr_next;
      lsu_vstart_skip <= uop_rd.rd_uop.vstart_skip;
      lsu_last        <= uop_rd.rd_uop.last_uop;
      lsu_pc          <= uop_rd.rd_uop.uop_pc;
    end
  end

endmodule

`default_nettype wire

// ==== src/rvv_lsu_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_lsu_decode_top #(
  parameter int VLEN        = 128,
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   inst_valid,
  input  rvv_lsu_pkg::INST_t                     inst,
  input  logic                                   lsu_ready,
  output logic                                   inst_ready,
  output logic                                   trap_valid,
  output logic [rvv_lsu_pkg::PC_WIDTH-1:0]       trap_pc,
  output logic                                   lsu_valid,
  output logic                                   lsu_store,
  output logic [rvv_lsu_pkg::VREG_WIDTH-1:0]     lsu_vreg,
  output rvv_lsu_pkg::EEW_e                      lsu_eew,
  output logic                                   lsu_mask_en,
  output logic [rvv_lsu_pkg::XLEN-1:0]           lsu_addr,
  output logic [rvv_lsu_pkg::VSTART_WIDTH-1:0]   lsu_vstart_skip,
  output logic                                   lsu_last,
  output logic [rvv_lsu_pkg::PC_WIDTH-1:0]       lsu_pc
);

  rvv_uop_if #(.payload_t(rvv_lsu_pkg::UOP_t), .QUEUE_DEPTH(QUEUE_DEPTH)) uop_if ();

  rvv_lsu_decode_ctrl #(.VLEN(VLEN)) i_ctrl (
    .clk, .reset, .inst_valid, .inst, .inst_ready, .trap_valid, .trap_pc,
    .uop_wr (uop_if.producer)
  );

  rvv_uop_queue #(.payload_t(rvv_lsu_pkg::UOP_t), .QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
    .clk, .reset,
    .q (uop_if.queue)
  );

  rvv_lsu_uop_issue #(.VLEN(VLEN)) i_issue (
    .clk, .reset, .lsu_ready,
    .uop_rd (uop_if.consumer),
    .lsu_valid, .lsu_store, .lsu_vreg, .lsu_eew, .lsu_mask_en,
    .lsu_addr, .lsu_vstart_skip, .lsu_last, .lsu_pc
  );

endmodule

`default_nettype wire

// ==== tests/rvv_lsu_decode_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_lsu_decode_sva #(
  parameter int QUEUE_DEPTH = 8
) (
  input logic                           clk,
  input logic                           reset,
  input logic                           inst_ready,
  input logic                           trap_valid,
  input logic                           lsu_valid,
  input logic                           lsu_ready,
  input logic [80:0]                    lsu_req,     // all request fields
  input logic [1:0]                     wr_valid,
  input logic [1:0]                     wr_last,     // last_uop per write slot
  input logic [$clog2(QUEUE_DEPTH):0]   free_count
);

  // stalled request holds
  assert property (@(posedge clk) disable iff (reset)
    lsu_valid && !lsu_ready |=> lsu_valid && $stable(lsu_req))
    else $error("lsu request changed while stalled");

  assert property (@(posedge clk) disable iff (reset) trap_valid |=> !trap_valid)
    else $error("trap pulse longer than one cycle");

  assert property (@(posedge clk) disable iff (reset)
    (int'(wr_valid[0]) + int'(wr_valid[1]) <= int'(free_count)) && (wr_valid[1] -> wr_valid[0]))
    else $error("queue write exceeds free space or skips slot 0");

  // held instruction is released only by its last uop or by a trap
  assert property (@(posedge clk) disable iff (reset)
    !inst_ready && !(|(wr_valid & wr_last)) |=> !inst_ready || trap_valid)
    else $error("inst_ready rose before the last uop was written");

endmodule

bind rvv_lsu_decode_top rvv_lsu_decode_sva #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_sva (
  .clk, .reset, .inst_ready, .trap_valid, .lsu_valid, .lsu_ready,
  .lsu_req    ({lsu_store, lsu_vreg, lsu_eew, lsu_mask_en, lsu_addr,
                lsu_vstart_skip, lsu_last, lsu_pc}),
  .wr_valid   (uop_if.wr_valid),
  .wr_last    ({uop_if.wr_uop[1].last_uop, uop_if.wr_uop[0].last_uop}),
  .free_count (uop_if.free_count)
);

`default_nettype wire

// ==== tests/rvv_lsu_decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_lsu_decode_tb;

  localparam int VLEN  = 128;
  localparam int VLENB = VLEN / 8;
  localparam logic [1:0] LD = 2'b00;
  localparam logic [1:0] ST = 2'b01;
  localparam logic [2:0] W8 = 3'b000;
  localparam logic [2:0] W16 = 3'b101;
  localparam logic [2:0] W32 = 3'b110;

  typedef struct {
    logic [1:0]  opc;
    logic [2:0]  width;
    logic [4:0]  vd;
    logic        vm;
    logic        vill;
    logic [2:0]  vsew;
    logic [2:0]  vlmul;
    logic [6:0]  vstart;
    logic [26:0] extra;   // nf, mew, mop, umop bits forced on
    bit          legal;
    int          pct;     // lsu_ready probability in percent
    logic [31:0] pc;
    logic [31:0] rs1;
  } stim_t;

  typedef struct {
    bit          store;
    logic [4:0]  vreg;
    int          eew_b;
    bit          mask;
    logic [31:0] addr;
    int          skip;
    bit          last;
    logic [31:0] pc;
  } exp_t;

  logic clk, reset, inst_valid, lsu_ready, inst_ready, trap_valid;
  logic lsu_valid, lsu_store, lsu_mask_en, lsu_last;
  logic [31:0] trap_pc, lsu_addr, lsu_pc;
  logic [4:0] lsu_vreg;
  logic [6:0] lsu_vstart_skip;
  rvv_lsu_pkg::EEW_e  lsu_eew;
  rvv_lsu_pkg::INST_t inst;

  stim_t       stim[$];
  exp_t        exp_q[$];
  logic [31:0] trap_q[$];
  int          ready_pct = 100;

  rvv_lsu_decode_top #(.VLEN(VLEN), .QUEUE_DEPTH(8)) i_rvv_lsu_decode_top (.*);

  always #2 clk = ~clk;

  // lsu_ready comes from this process, so the seed goes here
  initial begin
    void'($urandom(32'h57d0078e));
    forever begin
      @(posedge clk);
      #0.5;
      lsu_ready = ($urandom % 100) < ready_pct;
    end
  end

  task automatic stop_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic add(input logic [1:0] opc, input logic [2:0] width, input logic [4:0] vd,
                     input logic vm, input logic vill, input logic [2:0] vsew,
                     input logic [2:0] vlmul, input logic [6:0] vstart,
                     input logic [26:0] extra, input bit legal, input int pct);
    stim_t s;
    s = '{opc, width, vd, vm, vill, vsew, vlmul, vstart, extra, legal, pct,
          32'h8000_0000 + 32'(stim.size() * 4), 32'h2000_0013 + 32'(stim.size() * 'h104)};
    stim.push_back(s);
  endtask

  function automatic rvv_lsu_pkg::INST_t pack_inst(stim_t s);
    rvv_lsu_pkg::INST_t w;
    w.inst_pc                 = s.pc;
    w.inst                    = {6'd0, s.vm, 5'd0, 5'd0, s.width, s.vd, s.opc} | s.extra;
    w.rs1_data                = s.rs1;
    w.vector_csr.vtype.vill   = s.vill;
    w.vector_csr.vtype.vsew   = s.vsew;
    w.vector_csr.vtype.vlmul  = s.vlmul;
    w.vector_csr.vstart       = s.vstart;
    return w;
  endfunction

  // pushes expected uops in issue order and returns legality
  function automatic bit model(stim_t s);
    int eew_b, sew_b, lmul8, emul8, nuops, epr, first, offs, skip;
    exp_t e;
    case (s.width)
      W8:      eew_b = 1;
      W16:     eew_b = 2;
      W32:     eew_b = 4;
      default: eew_b = 0;
    endcase
    case (s.vlmul)   // lmul in eighths
      3'b000: lmul8 = 8;
      3'b001: lmul8 = 16;
      3'b010: lmul8 = 32;
      3'b011: lmul8 = 64;
      3'b101: lmul8 = 1;
      3'b110: lmul8 = 2;
      3'b111: lmul8 = 4;
      default: lmul8 = 0;
    endcase
    sew_b = 1 << s.vsew;
    if (eew_b == 0 || lmul8 == 0 || s.vill || s.vsew > 3 || s.opc[1] || s.extra != 0)
      return 0;
    emul8 = lmul8 * eew_b / sew_b;
    if (emul8 < 1 || emul8 > 64) return 0;
    nuops = (emul8 < 8) ? 1 : emul8 / 8;
    epr   = VLENB / eew_b;
    first = s.vstart / epr;
    offs  = s.vstart % epr;
    if (first >= nuops) return 0;   // everything lies before vstart
    for (int i = first; i < nuops; i++) begin
      skip = (i == first) ? offs : 0;
      e = '{s.opc[0], 5'(s.vd + i), eew_b, ~s.vm,
            s.rs1 + 32'(i * VLENB) + 32'(skip * eew_b), skip, i == nuops - 1, s.pc};
      exp_q.push_back(e);
    end
    return 1;
  endfunction

  task automatic compare_request();
    exp_t e;
    if (exp_q.size() == 0) begin
      $display("a request was issued with no uop left to expect");
      stop_run();
    end else begin
      e = exp_q.pop_front();
      check("lsu_pc", 64'(lsu_pc), 64'(e.pc));
      check("lsu_store", 64'(lsu_store), 64'(e.store));
      check("lsu_vreg", 64'(lsu_vreg), 64'(e.vreg));
      check("lsu_eew", 64'(1 << lsu_eew), 64'(e.eew_b));
      check("lsu_mask_en", 64'(lsu_mask_en), 64'(e.mask));
      check("lsu_addr", 64'(lsu_addr), 64'(e.addr));
      check("lsu_vstart_skip", 64'(lsu_vstart_skip), 64'(e.skip));
      check("lsu_last", 64'(lsu_last), 64'(e.last));
    end
  endtask

  task automatic compare_trap();
    if (trap_q.size() == 0) begin
      $display("trap raised for a legal instruction");
      stop_run();
    end else begin
      check("trap_pc", 64'(trap_pc), 64'(trap_q.pop_front()));
    end
  endtask

  always @(posedge clk) begin
    if (!reset && lsu_valid && lsu_ready) compare_request();
    if (!reset && trap_valid) compare_trap();
  end

  task automatic wait_inst_ready();
    int t = 0;
    while (!inst_ready) begin
      @(posedge clk);
      #0.5;
      t++;
      if (t > 2000) begin
        $display("timeout, inst_ready stayed low");
        stop_run();
      end
    end
  endtask

  task automatic wait_drain();
    int t = 0;
    while (exp_q.size() != 0 || trap_q.size() != 0 || !inst_ready) begin
      @(posedge clk);
      #0.5;
      t++;
      if (t > 4000) begin
        $display("timeout, expected uops or traps never arrived");
        stop_run();
      end
    end
  endtask

  initial begin
    bit legal;
    clk = 1'b0;
    reset = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    lsu_ready = 1'b0;
    // legal mixes, fractional lmul, vstart skips
    add(LD, W8,  5'd1,  1'b1, 1'b0, 3'd0, 3'b000, 7'd0,  27'h0, 1'b1, 70);
    add(ST, W16, 5'd4,  1'b0, 1'b0, 3'd0, 3'b000, 7'd0,  27'h0, 1'b1, 70);
    add(LD, W32, 5'd8,  1'b1, 1'b0, 3'd0, 3'b001, 7'd0,  27'h0, 1'b1, 70);
    add(LD, W8,  5'd3,  1'b1, 1'b0, 3'd2, 3'b111, 7'd0,  27'h0, 1'b1, 70);
    add(ST, W32, 5'd5,  1'b1, 1'b0, 3'd1, 3'b110, 7'd0,  27'h0, 1'b1, 70);
    add(LD, W16, 5'd30, 1'b0, 1'b0, 3'd1, 3'b010, 7'd11, 27'h0, 1'b1, 70);  // vreg wraps
    add(ST, W8,  5'd16, 1'b1, 1'b0, 3'd0, 3'b011, 7'd37, 27'h0, 1'b1, 70);
    add(LD, W32, 5'd12, 1'b1, 1'b0, 3'd2, 3'b001, 7'd4,  27'h0, 1'b1, 70);
    add(ST, W32, 5'd2,  1'b0, 1'b0, 3'd2, 3'b000, 7'd3,  27'h0, 1'b1, 70);
    // encodings and csr states that must trap
    add(LD, W8,  5'd1, 1'b1, 1'b0, 3'd0, 3'b000, 7'd0, 27'h100_0000, 1'b0, 70);  // nf
    add(ST, W16, 5'd1, 1'b1, 1'b0, 3'd0, 3'b000, 7'd0, 27'h080_0000, 1'b0, 70);  // mew
    add(LD, W32, 5'd1, 1'b1, 1'b0, 3'd0, 3'b000, 7'd0, 27'h040_0000, 1'b0, 70);  // strided
    add(ST, W8,  5'd1, 1'b1, 1'b0, 3'd0, 3'b000, 7'd0, 27'h020_0000, 1'b0, 70);  // indexed
    add(LD, W8,  5'd1, 1'b1, 1'b0, 3'd0, 3'b000, 7'd0, 27'h004_0000, 1'b0, 70);  // umop
    add(LD, 3'b111, 5'd1, 1'b1, 1'b0, 3'd0, 3'b000, 7'd0, 27'h0, 1'b0, 70);      // eew64
    add(LD, W8,  5'd1, 1'b1, 1'b1, 3'd0, 3'b000, 7'd0,  27'h0, 1'b0, 70);
    add(LD, W8,  5'd1, 1'b1, 1'b0, 3'd0, 3'b100, 7'd0,  27'h0, 1'b0, 70);
    add(LD, W32, 5'd1, 1'b1, 1'b0, 3'd0, 3'b011, 7'd0,  27'h0, 1'b0, 70);
    add(LD, W8,  5'd1, 1'b1, 1'b0, 3'd2, 3'b101, 7'd0,  27'h0, 1'b0, 70);
    add(LD, W8,  5'd1, 1'b1, 1'b0, 3'd0, 3'b000, 7'd20, 27'h0, 1'b0, 70);
    add(2'b10, W8, 5'd1, 1'b1, 1'b0, 3'd0, 3'b000, 7'd0, 27'h0, 1'b0, 70);
    // emul 8 back to back with a mostly stalled lsu
    add(LD, W32, 5'd0,  1'b1, 1'b0, 3'd0, 3'b001, 7'd0, 27'h0, 1'b1, 20);
    add(ST, W8,  5'd8,  1'b0, 1'b0, 3'd0, 3'b011, 7'd0, 27'h0, 1'b1, 20);
    add(LD, W16, 5'd16, 1'b1, 1'b0, 3'd1, 3'b011, 7'd0, 27'h0, 1'b1, 20);
    add(ST, W32, 5'd24, 1'b1, 1'b0, 3'd2, 3'b011, 7'd0, 27'h0, 1'b1, 20);
    add(LD, W16, 5'd4,  1'b0, 1'b0, 3'd0, 3'b010, 7'd0, 27'h0, 1'b1, 20);
    repeat (16) @(posedge clk);
    #0.5;
    reset = 1'b0;
    foreach (stim[n]) begin
      ready_pct = stim[n].pct;
      wait_inst_ready();
      inst_valid = 1'b1;
      inst = pack_inst(stim[n]);
      legal = model(stim[n]);
      check("model legality", 64'(legal), 64'(stim[n].legal));
      if (!stim[n].legal) trap_q.push_back(stim[n].pc);
      @(posedge clk);
      #0.5;
      inst_valid = 1'b0;
    end
    ready_pct = 100;
    wait_drain();
    if (lsu_valid) begin
      $display("a request is still pending with no uop left to expect");
      stop_run();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== rvv_lsu_decode_top.f ====
src/rvv_lsu_pkg.sv
src/rvv_uop_if.sv
src/rvv_backend_decode_unit_lsu.sv
src/rvv_lsu_decode_ctrl.sv
src/rvv_uop_queue.sv
src/rvv_lsu_uop_issue.sv
src/rvv_lsu_decode_top.sv
tests/rvv_lsu_decode_sva.sv
tests/rvv_lsu_decode_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rvv_lsu_decode_tb \
  -f rvv_lsu_decode_top.f -o rvv_lsu_decode_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/rvv_lsu_decode_sim > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
